// ==== design/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_addu = 4'd1,
        op_subu = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_slt  = 4'd6,
        op_lui  = 4'd7,
        op_mul  = 4'd8
    } alu_op_t;

    // primary opcode field, instr[31:26]
    localparam logic [5:0] OPC_SPECIAL  = 6'h00;
    localparam logic [5:0] OPC_SPECIAL2 = 6'h1c;
    localparam logic [5:0] OPC_ADDIU    = 6'h09;
    localparam logic [5:0] OPC_LUI      = 6'h0f;

    // function field, instr[5:0]
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_MUL  = 6'h02;

    typedef struct packed {
        alu_op_t   op;
        reg_addr_t dest;
        reg_addr_t src_a;
        reg_addr_t src_b;
        logic      use_imm;
        word_t     imm;
        logic      reg_write;
    } decoded_t;

    // must stay a power of two, pointers wrap by overflow
    parameter int QUEUE_DEPTH = 8;

endpackage

`default_nettype wire

// ==== design/instr_decode.sv ====
`default_nettype none

module instr_decode (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        flush,
    input  logic [1:0]                  fetch_valid,
    input  issue_pkg::word_t [1:0]      fetch_instr,
    input  logic                        push_ok,
    output logic                        fetch_ready,
    output logic [1:0]                  dec_valid,
    output issue_pkg::decoded_t [1:0]   dec_entry
);
    import issue_pkg::*;

    logic [1:0]  valid_q;
    word_t [1:0] instr_q;

    function automatic decoded_t decode_word(input word_t instr);
        decoded_t   d;
        logic [5:0] opcode;
        logic [5:0] funct;
        opcode = instr[31:26];
        funct  = instr[5:0];
        d      = '0;
        case (opcode)
            OPC_SPECIAL:
            begin
                case (funct)
                    FN_ADDU: d.op = op_addu;
                    FN_SUBU: d.op = op_subu;
                    FN_AND:  d.op = op_and;
                    FN_OR:   d.op = op_or;
                    FN_XOR:  d.op = op_xor;
                    FN_SLT:  d.op = op_slt;
                    default: d.op = op_nop;
                endcase
                d.dest  = instr[15:11];
                d.src_a = instr[25:21];
                d.src_b = instr[20:16];
            end
            OPC_SPECIAL2:
            begin
                d.op    = (funct == FN_MUL) ? op_mul : op_nop;
                d.dest  = instr[15:11];
                d.src_a = instr[25:21];
                d.src_b = instr[20:16];
            end
            OPC_ADDIU:
            begin
                d.op      = op_addu;
                d.dest    = instr[20:16];
                d.src_a   = instr[25:21];
                d.use_imm = 1'b1;
                d.imm     = {{16{instr[15]}}, instr[15:0]};
            end
            OPC_LUI:
            begin
                // src_a stays r0, the result is the immediate alone
                d.op      = op_lui;
                d.dest    = instr[20:16];
                d.use_imm = 1'b1;
                d.imm     = {instr[15:0], 16'h0000};
            end
            default: d.op = op_nop;
        endcase
        if (d.op == op_nop)
            d = '0;
        else
            d.reg_write = (d.dest != 5'd0);
        return d;
    endfunction

    // the held pair leaves when the queue takes it, or the register is empty
    assign fetch_ready = (valid_q == 2'b00) || push_ok;

    always_ff @(posedge clk)
    begin
        if (!reset || flush)
            valid_q <= 2'b00;
        else if (fetch_ready)
            valid_q <= fetch_valid;
    end

    always_ff @(posedge clk)
    begin
        if (fetch_ready)
            instr_q <= fetch_instr;
    end

    assign dec_valid    = valid_q;
    assign dec_entry[1] = decode_word(instr_q[1]);
    assign dec_entry[0] = decode_word(instr_q[0]);

endmodule

`default_nettype wire

// ==== design/issue_queue.sv ====
`default_nettype none

module issue_queue #(
    parameter int QUEUE_DEPTH = issue_pkg::QUEUE_DEPTH
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        flush,
    input  logic [1:0]                  dec_valid,
    input  issue_pkg::decoded_t [1:0]   dec_entry,
    input  logic [1:0]                  pop,
    output logic                        push_ok,
    output logic [1:0]                  head_valid,
    output issue_pkg::decoded_t [1:0]   head_entry
);
    import issue_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    decoded_t               entries [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0] valid;
    logic [PTR_W-1:0]       head;
    logic [PTR_W-1:0]       head_p1;
    logic [PTR_W-1:0]       tail;
    logic [PTR_W-1:0]       tail_p1;
    logic [1:0]             push_cnt;
    logic [1:0]             pop_cnt;
    logic                   free_tail;
    logic                   free_tail_p1;
    logic                   push_en;

    assign head_p1 = head + PTR_W'(1);
    assign tail_p1 = tail + PTR_W'(1);

    assign push_cnt = {1'b0, dec_valid[1]} + {1'b0, dec_valid[0]};
    assign pop_cnt  = {1'b0, pop[1]} + {1'b0, pop[1] & pop[0]};

    // a position counts as free when it is empty or leaves by this cycle's pop
    assign free_tail = !valid[tail]
                       || (pop[1] && tail == head)
                       || (pop[1] && pop[0] && tail == head_p1);
    assign free_tail_p1 = !valid[tail_p1]
                          || (pop[1] && tail_p1 == head)
                          || (pop[1] && pop[0] && tail_p1 == head_p1);

    always_comb
    begin
        case (push_cnt)
            2'd0:    push_ok = 1'b1;
            2'd1:    push_ok = free_tail;
            default: push_ok = free_tail && free_tail_p1;
        endcase
    end

    assign push_en = push_ok && (dec_valid != 2'b00);

    always_ff @(posedge clk)
    begin
        if (!reset || flush)
        begin
            head  <= '0;
            tail  <= '0;
            valid <= '0;
        end
        else
        begin
            // pops first, a push may reuse a slot freed in the same cycle
            if (pop[1])
                valid[head] <= 1'b0;
            if (pop[1] && pop[0])
                valid[head_p1] <= 1'b0;
            if (push_en)
            begin
                valid[tail] <= 1'b1;
                if (dec_valid == 2'b11)
                    valid[tail_p1] <= 1'b1;
                tail <= tail + PTR_W'(push_cnt);
            end
            head <= head + PTR_W'(pop_cnt);
        end
    end

    // lone slot 0 is compacted down to the tail position
    always_ff @(posedge clk)
    begin
        if (push_en)
        begin
            if (dec_valid[1])
                entries[tail] <= dec_entry[1];
            else
                entries[tail] <= dec_entry[0];
            if (dec_valid == 2'b11)
                entries[tail_p1] <= dec_entry[0];
        end
    end

    assign head_valid    = {valid[head], valid[head_p1]};
    assign head_entry[1] = entries[head];
    assign head_entry[0] = entries[head_p1];

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`default_nettype none

module reg_file (
    input  logic                        clk,
    input  issue_pkg::reg_addr_t [3:0]  rd_addr,
    output issue_pkg::word_t [3:0]      rd_data,
    input  logic [1:0]                  wr_en,
    input  issue_pkg::reg_addr_t [1:0]  wr_addr,
    input  issue_pkg::word_t [1:0]      wr_data
);
    import issue_pkg::*;

    word_t regs [32];

    // slot 0 is written last, so it wins on a shared target
    always_ff @(posedge clk)
    begin
        if (wr_en[1])
            regs[wr_addr[1]] <= wr_data[1];
        if (wr_en[0])
            regs[wr_addr[0]] <= wr_data[0];
    end

    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            if (rd_addr[i] == 5'd0)
                rd_data[i] = '0;
            else
                rd_data[i] = regs[rd_addr[i]];
        end
    end

endmodule

`default_nettype wire

// ==== design/dual_issue.sv ====
`default_nettype none

module dual_issue (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        flush,
    input  logic                        exec_stall,
    input  logic [1:0]                  head_valid,
    input  issue_pkg::decoded_t [1:0]   head_entry,
    output logic [1:0]                  pop,
    output logic [1:0]                  wb_en,
    output issue_pkg::reg_addr_t [1:0]  wb_reg,
    output issue_pkg::word_t [1:0]      wb_data
);
    import issue_pkg::*;

    decoded_t        older;
    decoded_t        younger;
    logic            raw;
    logic            dual_mul;
    reg_addr_t [3:0] rd_addr;
    word_t [3:0]     rd_data;
    word_t [3:0]     src_val;
    word_t [1:0]     opnd_a;
    word_t [1:0]     opnd_b;
    word_t [1:0]     result;
    word_t           mul_x;
    word_t           mul_y;
    word_t           product;
    logic [1:0]      issue_wr;

    function automatic word_t alu(input alu_op_t op, input word_t a, input word_t b);
        case (op)
            op_addu: return a + b;
            op_subu: return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_slt:  return {31'd0, $signed(a) < $signed(b)};
            op_lui:  return b;
            default: return '0;
        endcase
    endfunction

    assign older   = head_entry[1];
    assign younger = head_entry[0];

    assign raw = older.reg_write
                 && ((older.dest == younger.src_a)
                     || (!younger.use_imm && older.dest == younger.src_b));
    // one shared multiplier
    assign dual_mul = (older.op == op_mul) && (younger.op == op_mul);

    assign pop[1] = head_valid[1] && !exec_stall;
    assign pop[0] = pop[1] && head_valid[0] && !raw && !dual_mul;

    assign rd_addr = {older.src_a, older.src_b, younger.src_a, younger.src_b};

    reg_file u_reg_file (
        .clk     (clk),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr_en   (wb_en),
        .wr_addr (wb_reg),
        .wr_data (wb_data)
    );

    // bypass from the writeback register, slot 0 checked last so it wins
    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            src_val[i] = rd_data[i];
            if (wb_en[1] && wb_reg[1] == rd_addr[i])
                src_val[i] = wb_data[1];
            if (wb_en[0] && wb_reg[0] == rd_addr[i])
                src_val[i] = wb_data[0];
        end
    end

    assign opnd_a[1] = src_val[3];
    assign opnd_b[1] = older.use_imm ? older.imm : src_val[2];
    assign opnd_a[0] = src_val[1];
    assign opnd_b[0] = younger.use_imm ? younger.imm : src_val[0];

    assign mul_x   = (older.op == op_mul) ? opnd_a[1] : opnd_a[0];
    assign mul_y   = (older.op == op_mul) ? opnd_b[1] : opnd_b[0];
    assign product = mul_x * mul_y;

    assign result[1] = (older.op == op_mul) ? product : alu(older.op, opnd_a[1], opnd_b[1]);
    assign result[0] = (younger.op == op_mul) ? product : alu(younger.op, opnd_a[0], opnd_b[0]);

    assign issue_wr[1] = pop[1] && older.reg_write;
    assign issue_wr[0] = pop[0] && younger.reg_write;

    always_ff @(posedge clk)
    begin
        if (!reset || flush)
            wb_en <= 2'b00;
        else
            wb_en <= {|issue_wr, &issue_wr};
    end

    // an older nop hands slot 1 to the younger result
    always_ff @(posedge clk)
    begin
        if (issue_wr[1])
        begin
            wb_reg[1]  <= older.dest;
            wb_data[1] <= result[1];
        end
        else
        begin
            wb_reg[1]  <= younger.dest;
            wb_data[1] <= result[0];
        end
        wb_reg[0]  <= younger.dest;
        wb_data[0] <= result[0];
    end

endmodule

`default_nettype wire

// ==== design/issue_core.sv ====
`default_nettype none

module issue_core #(
    parameter int QUEUE_DEPTH = issue_pkg::QUEUE_DEPTH
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [1:0]                  fetch_valid,
    input  issue_pkg::word_t [1:0]      fetch_instr,
    output logic                        fetch_ready,
    input  logic                        exec_stall,
    input  logic                        flush,
    output logic [1:0]                  wb_en,
    output issue_pkg::reg_addr_t [1:0]  wb_reg,
    output issue_pkg::word_t [1:0]      wb_data
);
    import issue_pkg::*;

    logic [1:0]     dec_valid;
    decoded_t [1:0] dec_entry;
    logic           push_ok;
    logic [1:0]     head_valid;
    decoded_t [1:0] head_entry;
    logic [1:0]     pop;

    instr_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr),
        .push_ok     (push_ok),
        .fetch_ready (fetch_ready),
        .dec_valid   (dec_valid),
        .dec_entry   (dec_entry)
    );

    issue_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .dec_valid  (dec_valid),
        .dec_entry  (dec_entry),
        .pop        (pop),
        .push_ok    (push_ok),
        .head_valid (head_valid),
        .head_entry (head_entry)
    );

    dual_issue u_issue (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .exec_stall (exec_stall),
        .head_valid (head_valid),
        .head_entry (head_entry),
        .pop        (pop),
        .wb_en      (wb_en),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data)
    );

endmodule

`default_nettype wire

// ==== verification/issue_core_properties.sv ====
`default_nettype none

module issue_core_properties (
    input logic                       clk,
    input logic                       reset,
    input logic                       exec_stall,
    input logic                       flush,
    input logic [1:0]                 wb_en,
    input issue_pkg::reg_addr_t [1:0] wb_reg
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // the reset edges themselves are checked here
    wb_idle_after_reset: assert property (@(posedge clk) !reset |=> wb_en == 2'b00)
    else
    begin
        fail_count++;
        $error("wb_en set during reset or in the cycle after it");
    end

    wb_idle_after_flush: assert property (@(posedge clk) disable iff (!reset)
        flush |=> wb_en == 2'b00)
    else
    begin
        fail_count++;
        $error("wb_en set in the cycle after flush");
    end

    wb_idle_after_stall: assert property (@(posedge clk) disable iff (!reset)
        exec_stall |=> wb_en == 2'b00)
    else
    begin
        fail_count++;
        $error("wb_en set in the cycle after exec_stall");
    end

    // a single result always lands in slot 1
    wb_no_lone_slot0: assert property (@(posedge clk) disable iff (!reset) wb_en != 2'b01)
    else
    begin
        fail_count++;
        $error("wb_en shows slot 0 alone");
    end

    wb_reg_not_r0: assert property (@(posedge clk) disable iff (!reset)
        !(wb_en[1] && wb_reg[1] == 5'd0) && !(wb_en[0] && wb_reg[0] == 5'd0))
    else
    begin
        fail_count++;
        $error("writeback enabled towards r0");
    end

endmodule

`default_nettype wire

// ==== verification/issue_core_tb.sv ====
`default_nettype none

module issue_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N = 120;
    localparam int CYCLE_LIMIT = 10 * N + 200;
    localparam int K_ADDIU = 6;
    localparam int K_LUI = 7;
    localparam int K_MUL = 8;
    localparam int K_NOP = 9;
    // addu subu and or xor slt
    localparam logic [5:0] FUNCT [6] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a};

    logic             clk = 1'b0;
    logic             reset;
    logic [1:0]       fetch_valid;
    logic [1:0][31:0] fetch_instr;
    logic             fetch_ready;
    logic             exec_stall;
    logic             flush;
    logic [1:0]       wb_en;
    logic [1:0][4:0]  wb_reg;
    logic [1:0][31:0] wb_data;

    int          kind_of [N];
    logic [4:0]  dest_of [N];
    logic [4:0]  rs_of [N];
    logic [4:0]  rt_of [N];
    logic [15:0] imm_of [N];
    logic [31:0] word_of [N];
    logic [31:0] model_regs [32];
    logic [31:0] lfsr = 32'h55b3_5b9d;
    int          pending [$];
    int          offer_idx [2];
    bit          offer_open = 1'b0;
    bit          dual_seen = 1'b0;
    int          next_idx = 0;
    int          cycles = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          writers_in = 0;
    int          writers_dropped = 0;
    int          wb_count = 0;

    issue_core DUT (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr),
        .fetch_ready (fetch_ready),
        .exec_stall  (exec_stall),
        .flush       (flush),
        .wb_en       (wb_en),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data)
    );

    bind issue_core issue_core_properties u_props (
        .clk        (clk),
        .reset      (reset),
        .exec_stall (exec_stall),
        .flush      (flush),
        .wb_en      (wb_en),
        .wb_reg     (wb_reg)
    );

    always #10 clk = ~clk;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic bit writes(input int idx);
        return kind_of[idx] != K_NOP && dest_of[idx] != 5'd0;
    endfunction

    function automatic int pending_writers();
        int n;
        n = 0;
        foreach (pending[p])
        begin
            if (writes(pending[p]))
                n++;
        end
        return n;
    endfunction

    function automatic logic [31:0] model_result(input int idx);
        logic [31:0] a;
        logic [31:0] b;
        a = model_regs[rs_of[idx]];
        b = model_regs[rt_of[idx]];
        case (kind_of[idx])
            0:       return a + b;
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            4:       return a ^ b;
            5:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            K_ADDIU: return a + {{16{imm_of[idx][15]}}, imm_of[idx]};
            K_LUI:   return {imm_of[idx], 16'h0000};
            default: return a * b;
        endcase
    endfunction

    // read-after-write on either source, or both using the multiplier
    function automatic bit must_issue_alone(input int older, input int younger);
        bit reads_b;
        reads_b = kind_of[younger] < K_ADDIU || kind_of[younger] == K_MUL;
        if (kind_of[older] == K_MUL && kind_of[younger] == K_MUL)
            return 1'b1;
        return rs_of[younger] == dest_of[older]
               || (reads_b && rt_of[younger] == dest_of[older]);
    endfunction

    task automatic build_program();
        logic [3:0] v;
        for (int i = 0; i < N; i++)
        begin
            imm_of[i] = 16'(random_bits(16));
            rs_of[i] = 5'(random_bits(5));
            rt_of[i] = 5'(random_bits(5));
            dest_of[i] = 5'(random_bits(5));
            if (i < 31)
            begin
                // every register gets a known value before anything reads it
                kind_of[i] = random_bits(1) ? K_LUI : K_ADDIU;
                dest_of[i] = 5'(i + 1);
                rs_of[i] = 5'(rs_of[i] % (i + 1));
            end
            else if (i < 51)
            begin
                // reads r0..r15 and writes r16..r31, so no pair depends on another
                kind_of[i] = random_bits(3);
                dest_of[i][4] = 1'b1;
                rs_of[i][4] = 1'b0;
                rt_of[i][4] = 1'b0;
            end
            else
            begin
                v = 4'(random_bits(4));
                kind_of[i] = (v < 8) ? v : ((v < 13) ? K_MUL : K_NOP);
                if (random_bits(2) == 0)
                    rs_of[i] = dest_of[i - 1];
                if (random_bits(3) == 0)
                    dest_of[i] = 5'd0;
            end
            if (kind_of[i] == K_LUI)
                rs_of[i] = 5'd0;
            case (kind_of[i])
                K_ADDIU: word_of[i] = {6'h09, rs_of[i], dest_of[i], imm_of[i]};
                K_LUI:   word_of[i] = {6'h0f, 5'd0, dest_of[i], imm_of[i]};
                K_MUL:   word_of[i] = {6'h1c, rs_of[i], rt_of[i], dest_of[i], 5'd0, 6'h02};
                // load and shift shapes sit outside the subset
                K_NOP:   word_of[i] = imm_of[i][0] ? {6'h23, rs_of[i], dest_of[i], imm_of[i]}
                                        : {6'h00, rs_of[i], rt_of[i], dest_of[i], 11'd0};
                default: word_of[i] = {6'h00, rs_of[i], rt_of[i], dest_of[i], 5'd0,
                                       FUNCT[kind_of[i]]};
            endcase
        end
    endtask

    task automatic make_offer();
        int g;
        g = random_bits(3);
        fetch_valid = 2'b00;
        fetch_instr = {2{32'hffff_ffff}};
        if (next_idx < N && g != 0)
        begin
            if (g == 2)
            begin
                // lone slot 0 makes the queue compact it
                fetch_valid = 2'b01;
                fetch_instr[0] = word_of[next_idx];
                offer_idx[0] = next_idx;
            end
            else if (g == 1 || next_idx == N - 1)
            begin
                fetch_valid = 2'b10;
                fetch_instr[1] = word_of[next_idx];
                offer_idx[1] = next_idx;
            end
            else
            begin
                fetch_valid = 2'b11;
                fetch_instr[1] = word_of[next_idx];
                fetch_instr[0] = word_of[next_idx + 1];
                offer_idx[1] = next_idx;
                offer_idx[0] = next_idx + 1;
            end
            offer_open = 1'b1;
        end
    endtask

    task automatic take_writeback(input int slot, output int idx);
        logic [31:0] expected;
        idx = -1;
        while (pending.size() > 0 && !writes(pending[0]))
            void'(pending.pop_front());
        if (pending.size() == 0)
        begin
            other_errors++;
            $display("writeback on slot %0d with no instruction left to retire", slot);
            return;
        end
        idx = pending.pop_front();
        expected = model_result(idx);
        assert (wb_reg[slot] == dest_of[idx])
        else
        begin
            value_errors++;
            $display("FAIL wb_reg[%0d]: expected %h, got %h", slot, dest_of[idx], wb_reg[slot]);
        end
        assert (wb_data[slot] == expected)
        else
        begin
            value_errors++;
            $display("FAIL wb_data[%0d]: expected %h, got %h", slot, expected, wb_data[slot]);
        end
        model_regs[dest_of[idx]] = expected;
        wb_count++;
    endtask

    // retire writebacks first, then take the fetch, then apply flush
    always @(posedge clk)
    begin
        int older;
        int younger;
        if (reset)
        begin
            cycles++;
            if (cycles > CYCLE_LIMIT)
            begin
                $display("timeout after %0d cycles with %0d writebacks still due",
                         CYCLE_LIMIT, pending_writers());
                $display("Finished with errors");
                $finish;
            end
            else
            begin
                older = -1;
                younger = -1;
                if (wb_en[1])
                    take_writeback(1, older);
                if (wb_en[0])
                    take_writeback(0, younger);
                if (wb_en == 2'b11 && older >= 0 && younger >= 0)
                begin
                    dual_seen = 1'b1;
                    assert (!must_issue_alone(older, younger))
                    else
                    begin
                        other_errors++;
                        $display("instructions %0d and %0d retired together but may not pair",
                                 older, younger);
                    end
                end
                if (offer_open && fetch_ready && !flush)
                begin
                    for (int s = 1; s >= 0; s--)
                    begin
                        if (fetch_valid[s])
                        begin
                            pending.push_back(offer_idx[s]);
                            if (writes(offer_idx[s]))
                                writers_in++;
                        end
                    end
                    next_idx += fetch_valid[1] + fetch_valid[0];
                    offer_open = 1'b0;
                end
                if (flush)
                begin
                    writers_dropped += pending_writers();
                    pending.delete();
                end
            end
        end
    end

    initial
    begin
        int flushes;
        flushes = 0;
        reset = 1'b0;
        fetch_valid = 2'b00;
        fetch_instr = '0;
        exec_stall = 1'b0;
        flush = 1'b0;
        foreach (model_regs[r])
            model_regs[r] = '0;
        build_program();
        repeat (2) @(negedge clk);
        reset = 1'b1;
        while (next_idx < N || pending_writers() > 0)
        begin
            exec_stall = (random_bits(3) == 0);
            flush = 1'b0;
            if (flushes < 2 && next_idx >= 84 + 20 * flushes)
            begin
                flush = 1'b1;
                flushes++;
                offer_open = 1'b0;
                fetch_valid = 2'b00;
            end
            else if (!offer_open)
                make_offer();
            @(negedge clk);
        end
        fetch_valid = 2'b00;
        exec_stall = 1'b0;
        flush = 1'b0;
        // idle a few cycles so a stray writeback still shows up
        repeat (4) @(negedge clk);
        assert (dual_seen)
        else
        begin
            other_errors++;
            $display("no cycle retired two instructions at once");
        end
        assert (wb_count == writers_in - writers_dropped)
        else
        begin
            other_errors++;
            $display("%0d writebacks seen where %0d were due",
                     wb_count, writers_in - writers_dropped);
        end
        $display("errors: %0d value, %0d other, %0d property",
                 value_errors, other_errors, DUT.u_props.fail_count);
        if (value_errors + other_errors + DUT.u_props.fail_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== issue_core.f ====
design/issue_pkg.sv
design/instr_decode.sv
design/issue_queue.sv
design/reg_file.sv
design/dual_issue.sv
design/issue_core.sv
verification/issue_core_properties.sv
verification/issue_core_tb.sv
